// ==== mipsByteRam.sv ====
`timescale 1ns/1ps
`include "mipsLsu_config.svh"

module mipsByteRam #(
	parameter int MEM_WORDS = `MEM_WORDS
) (
	input logic clk,
	input logic [$clog2(MEM_WORDS)-1:0] wordAddr,
	input logic [3:0] byteEn,
	input logic [31:0] wrData,
	output logic [31:0] rdData
);

	logic [31:0] mem [MEM_WORDS];

	always_ff @(posedge clk) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (byteEn[lane]) begin
				mem[wordAddr][lane*8 +: 8] <= wrData[lane*8 +: 8];
			end
		end
		rdData <= mem[wordAddr]; // Old contents on a same-edge write
	end

endmodule

// ==== mipsLsu.f ====
+incdir+.
mipsLsuPkg.sv
mipsLsuDecode.sv
mipsLsuExecute.sv
mipsByteRam.sv
mipsLsuMemory.sv
mipsLsuResult.sv
mipsLsu.sv
mipsLsu_asserts.sv
mipsLsuChecker.sv
mipsLsuTb.sv

// ==== mipsLsu.sv ====
`timescale 1ns/1ps

module mipsLsu import mipsLsuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic [31:0] instr,
	input logic [31:0] baseValue,
	input logic [31:0] storeValue,
	output logic wbValid,
	output logic [4:0] wbReg,
	output logic [31:0] wbData,
	output logic fault
);

	decodedT decoded;
	accessT access;
	resultT result;

	mipsLsuDecode decodeInst (
		.inValid(inValid),
		.instr(instr),
		.baseValue(baseValue),
		.storeValue(storeValue),
		.decoded(decoded)
	);

	mipsLsuExecute executeInst (
		.clk(clk),
		.rstN(rstN),
		.decoded(decoded),
		.access(access)
	);

	mipsLsuMemory memoryInst (
		.clk(clk),
		.rstN(rstN),
		.access(access),
		.result(result)
	);

	mipsLsuResult resultInst (
		.clk(clk),
		.rstN(rstN),
		.result(result),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.fault(fault)
	);

endmodule

// ==== mipsLsuChecker.sv ====
`timescale 1ns/1ps
`include "mipsLsu_config.svh"

module mipsLsuChecker (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic [31:0] instr,
	input logic [31:0] baseValue,
	input logic [31:0] storeValue,
	input logic wbValid,
	input logic [4:0] wbReg,
	input logic [31:0] wbData,
	input logic fault,
	output int errorCount,
	output int checkCount
);

	typedef struct packed {
		logic wb;
		logic flt;
		logic [4:0] dest;
		logic [31:0] data;
	} expectT;

	logic [7:0] memModel [256];
	expectT pending [$];

	// Expected outcome of one instruction under the load/store rules
	function automatic expectT predict(input logic [31:0] ins, input logic [31:0] base);
		expectT e;
		logic [31:0] addr;
		logic [7:0] a;
		e = '0;
		e.dest = ins[`RT_HI:`RT_LO];
		addr = base + {{16{ins[15]}}, ins[15:0]};
		a = addr[7:0];
		case (ins[`OPCODE_HI:`OPCODE_LO])
			`OPC_LB: e.data = {{24{memModel[a][7]}}, memModel[a]};
			`OPC_LBU: e.data = {24'h0, memModel[a]};
			`OPC_LH: e.data = {{16{memModel[a + 1][7]}}, memModel[a + 1], memModel[a]};
			`OPC_LHU: e.data = {16'h0, memModel[a + 1], memModel[a]};
			`OPC_LW: e.data = {memModel[a + 3], memModel[a + 2], memModel[a + 1], memModel[a]};
			default: e.data = '0;
		endcase
		case (ins[`OPCODE_HI:`OPCODE_LO])
			`OPC_LB, `OPC_LBU: e.wb = 1'b1;
			`OPC_LH, `OPC_LHU: {e.flt, e.wb} = addr[0] ? 2'b10 : 2'b01;
			`OPC_LW: {e.flt, e.wb} = (addr[1:0] != 0) ? 2'b10 : 2'b01;
			`OPC_SH: e.flt = addr[0];
			`OPC_SW: e.flt = (addr[1:0] != 0);
			default: e.wb = 1'b0;
		endcase
		return e;
	endfunction

	task automatic storeModel(input logic [31:0] ins, input logic [31:0] base,
			input logic [31:0] data);
		logic [31:0] addr;
		logic [7:0] a;
		addr = base + {{16{ins[15]}}, ins[15:0]};
		a = addr[7:0];
		case (ins[`OPCODE_HI:`OPCODE_LO])
			`OPC_SB: memModel[a] = data[7:0];
			`OPC_SH: if (!addr[0]) {memModel[a + 1], memModel[a]} = data[15:0];
			`OPC_SW: if (addr[1:0] == 0) begin
				{memModel[a + 3], memModel[a + 2], memModel[a + 1], memModel[a]} = data;
			end
			default: ;
		endcase
	endtask

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	always @(posedge clk) begin
		expectT e;
		expectT got;
		e = '0;
		if (rstN && inValid) begin
			e = predict(instr, baseValue);
			storeModel(instr, baseValue, storeValue);
		end
		pending.push_back(e);
		// Outputs seen here were set two edges after the oldest entry
		if (pending.size() > 3) begin
			got = pending.pop_front();
			checkCount++;
			if (got.wb && !wbValid) begin
				$display("Missing write-back strobe at %0t", $time);
				errorCount++;
			end else if (!got.wb && wbValid) begin
				$display("Unexpected write-back strobe at %0t", $time);
				errorCount++;
			end
			if (got.flt != fault) begin
				$display("Fault strobe was %0b where %0b was due at %0t", fault, got.flt, $time);
				errorCount++;
			end
			if (got.wb && wbValid && (wbReg !== got.dest || wbData !== got.data)) begin
				$display("error at %0t: write-back r%0d=%h, expected r%0d=%h", $time,
					wbReg, wbData, got.dest, got.data);
				errorCount++;
			end
		end
	end

endmodule

// ==== mipsLsuDecode.sv ====
`timescale 1ns/1ps
`include "mipsLsu_config.svh"

module mipsLsuDecode import mipsLsuPkg::*; (
	input logic inValid,
	input logic [31:0] instr,
	input logic [31:0] baseValue,
	input logic [31:0] storeValue,
	output decodedT decoded
);

	opcodeE op;
	logic [5:0] opField;

	assign opField = instr[`OPCODE_HI:`OPCODE_LO];

	always_comb begin
		case (opField)
			`OPC_LB: op = OP_LB;
			`OPC_LBU: op = OP_LBU;
			`OPC_LH: op = OP_LH;
			`OPC_LHU: op = OP_LHU;
			`OPC_LW: op = OP_LW;
			`OPC_SB: op = OP_SB;
			`OPC_SH: op = OP_SH;
			`OPC_SW: op = OP_SW;
			default: op = OP_NONE; // ALU, branch and everything else
		endcase
	end

	always_comb begin
		decoded.valid = inValid;
		decoded.ctrl.width = W_NONE;
		decoded.ctrl.signExt = 1'b0;
		decoded.ctrl.writeEn = 1'b0;
		decoded.ctrl.isLoad = 1'b0;
		decoded.ctrl.destReg = instr[`RT_HI:`RT_LO];
		decoded.offset = instr[`IMM_HI:`IMM_LO];
		decoded.base = baseValue;
		decoded.storeData = storeValue;
		case (op)
			OP_LB, OP_LBU: begin
				decoded.ctrl.width = W_BYTE;
				decoded.ctrl.signExt = (op == OP_LB);
				decoded.ctrl.isLoad = 1'b1;
			end
			OP_LH, OP_LHU: begin
				decoded.ctrl.width = W_HALF;
				decoded.ctrl.signExt = (op == OP_LH);
				decoded.ctrl.isLoad = 1'b1;
			end
			OP_LW: begin
				decoded.ctrl.width = W_WORD;
				decoded.ctrl.isLoad = 1'b1;
			end
			OP_SB: begin
				decoded.ctrl.width = W_BYTE;
				decoded.ctrl.writeEn = 1'b1;
			end
			OP_SH: begin
				decoded.ctrl.width = W_HALF;
				decoded.ctrl.writeEn = 1'b1;
			end
			OP_SW: begin
				decoded.ctrl.width = W_WORD;
				decoded.ctrl.writeEn = 1'b1;
			end
			default: decoded.valid = 1'b0; // Not a memory instruction, drop it
		endcase
	end

endmodule

// ==== mipsLsuExecute.sv ====
`timescale 1ns/1ps

module mipsLsuExecute import mipsLsuPkg::*; (
	input logic clk,
	input logic rstN,
	input decodedT decoded,
	output accessT access
);

	logic [31:0] effAddr;
	logic misaligned;
	accessT accessNext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address generation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign effAddr = decoded.base + {{16{decoded.offset[15]}}, decoded.offset};

	always_comb begin
		case (decoded.ctrl.width)
			W_HALF: misaligned = effAddr[0];
			W_WORD: misaligned = |effAddr[1:0];
			default: misaligned = 1'b0; // Bytes are always aligned
		endcase
	end

	always_comb begin
		accessNext.valid = decoded.valid;
		accessNext.ctrl = decoded.ctrl;
		accessNext.addr = effAddr;
		// Move the store data up to the lane it lands on
		accessNext.laneData = decoded.storeData << {effAddr[1:0], 3'b000};
		accessNext.misaligned = misaligned;
	end

	always_ff @(posedge clk) begin
		access <= accessNext;
		if (!rstN) begin
			access.valid <= 1'b0;
		end
	end

endmodule

// ==== mipsLsuMemory.sv ====
`timescale 1ns/1ps
`include "mipsLsu_config.svh"

module mipsLsuMemory import mipsLsuPkg::*; (
	input logic clk,
	input logic rstN,
	input accessT access,
	output resultT result
);

	logic [3:0] laneMask;
	logic [3:0] byteEn;
	logic [31:0] rdData;
	memControlT ctrlQ;
	logic [1:0] laneQ;
	logic validQ;
	logic faultQ;
	logic [31:0] shifted;
	logic msb;
	logic [31:0] loadData;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lane enables and RAM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (access.ctrl.width)
			W_NONE: laneMask = 4'b0000;
			W_BYTE: laneMask = 4'b0001;
			W_HALF: laneMask = 4'b0011;
			W_WORD: laneMask = 4'b1111;
			default: laneMask = 4'b0000;
		endcase
	end

	assign byteEn = (access.valid && access.ctrl.writeEn && !access.misaligned)
		? laneMask << access.addr[1:0]
		: 4'b0000;

	mipsByteRam #(
		.MEM_WORDS(`MEM_WORDS)
	) ramInst (
		.clk(clk),
		.wordAddr(access.addr[`ADDR_W-1:2]), // Upper bits dropped so addresses wrap
		.byteEn(byteEn),
		.wrData(access.laneData),
		.rdData(rdData)
	);

	always_ff @(posedge clk) begin
		ctrlQ <= access.ctrl;
		laneQ <= access.addr[1:0];
		faultQ <= access.misaligned;
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= access.valid;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read alignment and extension
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		shifted = rdData >> {laneQ, 3'b000}; // Addressed lane down to bit 0
		case (ctrlQ.width)
			W_BYTE: msb = shifted[7];
			W_HALF: msb = shifted[15];
			default: msb = 1'b0;
		endcase
		case (ctrlQ.width)
			W_BYTE: loadData = {{24{ctrlQ.signExt & msb}}, shifted[7:0]};
			W_HALF: loadData = {{16{ctrlQ.signExt & msb}}, shifted[15:0]};
			W_WORD: loadData = shifted;
			default: loadData = 32'h0;
		endcase
	end

	assign result = '{
		valid: validQ,
		isLoad: ctrlQ.isLoad,
		fault: faultQ,
		destReg: ctrlQ.destReg,
		data: loadData
	};

endmodule

// ==== mipsLsuPkg.sv ====
package mipsLsuPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operation encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		OP_NONE,
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_SB,
		OP_SH,
		OP_SW
	} opcodeE;

	typedef enum logic [1:0] {
		W_NONE,
		W_BYTE,
		W_HALF,
		W_WORD
	} widthE;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		widthE width;
		logic signExt;
		logic writeEn;
		logic isLoad;
		logic [4:0] destReg; // rt field, the load target
	} memControlT;

	typedef struct packed {
		logic valid;
		memControlT ctrl;
		logic [15:0] offset;
		logic [31:0] base;
		logic [31:0] storeData;
	} decodedT;

	typedef struct packed {
		logic valid;
		memControlT ctrl;
		logic [31:0] addr; // Full effective address before wrapping
		logic [31:0] laneData;
		logic misaligned;
	} accessT;

	typedef struct packed {
		logic valid;
		logic isLoad;
		logic fault;
		logic [4:0] destReg;
		logic [31:0] data;
	} resultT;

endpackage

// ==== mipsLsuResult.sv ====
`timescale 1ns/1ps

module mipsLsuResult import mipsLsuPkg::*; (
	input logic clk,
	input logic rstN,
	input resultT result,
	output logic wbValid,
	output logic [4:0] wbReg,
	output logic [31:0] wbData,
	output logic fault
);

	logic loadDone;

	assign loadDone = result.valid && result.isLoad && !result.fault;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			fault <= 1'b0;
		end else begin
			wbValid <= loadDone;
			fault <= result.valid && result.fault; // Loads and stores alike
		end
	end

	always_ff @(posedge clk) begin
		if (loadDone) begin
			wbReg <= result.destReg;
			wbData <= result.data;
		end
	end

endmodule

// ==== mipsLsuTb.sv ====
`timescale 1ns/1ps
`include "mipsLsu_config.svh"

module mipsLsuTb;

	localparam int TEST_CYCLES = 470;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 50;

	logic clk;
	logic rstN;
	logic inValid;
	logic [31:0] instr;
	logic [31:0] baseValue;
	logic [31:0] storeValue;
	logic wbValid;
	logic [4:0] wbReg;
	logic [31:0] wbData;
	logic fault;
	int errorCount;
	int checkCount;
	int cycleCount;
	int seed;

	mipsLsu mipsLsu_inst (.*);

	mipsLsuChecker checkerInst (.*);

	bind mipsLsu mipsLsu_asserts assertsInst (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Puts one instruction on the inputs for the next rising edge
	task automatic sendInstr(input logic [5:0] op, input logic [4:0] rt,
			input logic [15:0] offset, input logic [31:0] base, input logic [31:0] data);
		@(negedge clk);
		inValid = 1'b1;
		instr = {op, 5'd0, rt, offset};
		baseValue = base;
		storeValue = data;
	endtask

	task automatic idleCycle();
		@(negedge clk);
		inValid = 1'b0;
	endtask

	function automatic logic [31:0] fillWord(input logic [7:0] addr);
		return {addr, ~addr, addr ^ 8'h5A, addr + 8'h33};
	endfunction

	initial begin
		logic [5:0] randOps [10];
		int total;
		seed = 24967;
		randOps = '{`OPC_LB, `OPC_LBU, `OPC_LH, `OPC_LHU, `OPC_LW,
			`OPC_SB, `OPC_SH, `OPC_SW, 6'h00, 6'h08};
		rstN = 1'b0;
		inValid = 1'b0;
		instr = '0;
		baseValue = '0;
		storeValue = '0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// Whole memory by words, with wrapping bases
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		for (int i = 0; i < 64; i++) begin
			sendInstr(`OPC_SW, 5'd0, 16'hFF00, 32'h1100 + i * 4, fillWord(8'(i * 4)));
		end
		for (int i = 0; i < 64; i++) begin
			sendInstr(`OPC_LW, 5'(i), 16'h0000, 32'h300 + i * 4, 32'h0);
		end
		// Sub-word loads in every lane
		sendInstr(`OPC_SW, 5'd0, 16'h0040, 32'h0, 32'h80F1_7F82);
		for (int l = 0; l < 4; l++) begin
			sendInstr(`OPC_LB, 5'd1, 16'(64 + l), 32'h0, 32'h0);
			sendInstr(`OPC_LBU, 5'd2, 16'(64 + l), 32'h0, 32'h0);
		end
		for (int l = 0; l < 4; l += 2) begin
			sendInstr(`OPC_LH, 5'd3, 16'(64 + l), 32'h0, 32'h0);
			sendInstr(`OPC_LHU, 5'd4, 16'(64 + l), 32'h0, 32'h0);
		end
		// Partial stores keep the other lanes
		sendInstr(`OPC_SB, 5'd0, 16'h0045, 32'h0, 32'hFFFF_FFC7);
		sendInstr(`OPC_LW, 5'd5, 16'h0044, 32'h0, 32'h0);
		sendInstr(`OPC_SH, 5'd0, 16'h0046, 32'h0, 32'h1234_BEEF);
		sendInstr(`OPC_LW, 5'd6, 16'h0044, 32'h0, 32'h0);
		// Misaligned accesses fault and leave memory alone
		sendInstr(`OPC_LH, 5'd7, 16'h0049, 32'h0, 32'h0);
		sendInstr(`OPC_LW, 5'd8, 16'h004A, 32'h0, 32'h0);
		sendInstr(`OPC_SH, 5'd0, 16'h004B, 32'h0, 32'hDEAD_DEAD);
		sendInstr(`OPC_SW, 5'd0, 16'h0049, 32'h0, 32'hDEAD_DEAD);
		sendInstr(`OPC_SW, 5'd0, 16'h004E, 32'h0, 32'hDEAD_DEAD);
		sendInstr(`OPC_LW, 5'd9, 16'h0048, 32'h0, 32'h0);
		sendInstr(`OPC_LW, 5'd10, 16'h004C, 32'h0, 32'h0);
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// Random mix on every cycle
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		for (int i = 0; i < 300; i++) begin
			sendInstr(randOps[$unsigned($random(seed)) % 10], 5'($random(seed)),
				16'($random(seed)), $random(seed), $random(seed));
			inValid = ($unsigned($random(seed)) % 8) != 0;
		end
		repeat (6) idleCycle();
		@(negedge clk);
		total = errorCount + mipsLsu_inst.assertsInst.failCount;
		$display("Checks: %0d, mismatches: %0d, assertion failures: %0d", checkCount,
			errorCount, mipsLsu_inst.assertsInst.failCount);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		cycleCount = 0;
		forever begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount >= CYCLE_LIMIT) begin
				$display("Timeout: the run passed %0d cycles without finishing", CYCLE_LIMIT);
				$display("Errors found");
				$finish;
			end
		end
	end

endmodule

// ==== mipsLsu_asserts.sv ====
`timescale 1ns/1ps
`include "mipsLsu_config.svh"

module mipsLsu_asserts (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic [31:0] instr,
	input logic wbValid,
	input logic fault
);

	int failCount = 0;
	logic memOp;

	assign memOp = instr[`OPCODE_HI:`OPCODE_LO] inside {`OPC_LB, `OPC_LBU, `OPC_LH,
		`OPC_LHU, `OPC_LW, `OPC_SB, `OPC_SH, `OPC_SW};

	quietAfterReset: assert property (@(posedge clk) !rstN |=> !wbValid && !fault)
		else begin
			failCount++;
			$error("Strobe right after reset");
		end

	oneStrobe: assert property (@(posedge clk) disable iff (!rstN) !(wbValid && fault))
		else begin
			failCount++;
			$error("Write-back and fault together");
		end

	// Outputs registered two edges after issue are sampled on the third
	nonMemSilent: assert property (@(posedge clk) disable iff (!rstN)
		inValid && !memOp |-> ##3 !wbValid && !fault)
		else begin
			failCount++;
			$error("Strobe from a non-memory opcode");
		end

endmodule

// ==== mipsLsu_config.svh ====
`ifndef MIPSLSU_CONFIG_SVH
`define MIPSLSU_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MEM_WORDS 64
`define ADDR_W 8 // Byte address bits, log2 of MEM_WORDS plus two

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I-type instruction fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define OPCODE_HI 31
`define OPCODE_LO 26
`define RT_HI 20
`define RT_LO 16
`define IMM_HI 15
`define IMM_LO 0

// Primary opcode values of the MIPS memory instructions
`define OPC_LB 6'h20
`define OPC_LH 6'h21
`define OPC_LW 6'h23
`define OPC_LBU 6'h24
`define OPC_LHU 6'h25
`define OPC_SB 6'h28
`define OPC_SH 6'h29
`define OPC_SW 6'h2B

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
verilator --binary --timing --assert --top-module mipsLsuTb -f mipsLsu.f -o simv \
	&& ./obj_dir/simv +verilator+error+limit+1000 > sim.log \
	; cat sim.log \
	&& grep -qx "No errors" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
